//--- bench/dma_top_chk.sv
module dma_top_chk (
    input logic core_clk,
    input logic rst_n,
    input logic req_valid,
    input logic req_ready,
    input logic rsp_valid,
    input logic cmd_valid,
    input logic cmd_ready,
    input logic done
);

    // Set between command acceptance and done
    logic cmd_busy;

    always_ff @(posedge core_clk) begin
        if (!rst_n) begin
            cmd_busy <= 1'b0;
        end else if (cmd_valid && cmd_ready) begin
            cmd_busy <= 1'b1;
        end else if (done) begin
            cmd_busy <= 1'b0;
        end
    end

    a_rsp_after_req: assert property (@(posedge core_clk) disable iff (!rst_n)
        $rose(rsp_valid) |-> $past(req_valid && req_ready))
        else $error("rsp_valid rose without a request transfer one cycle earlier");

    a_cmd_ready_low: assert property (@(posedge core_clk) disable iff (!rst_n)
        (cmd_busy && !done) |-> !cmd_ready)
        else $error("cmd_ready high while a command is still running");

    a_done_pulse: assert property (@(posedge core_clk) disable iff (!rst_n)
        done |=> !done)
        else $error("done held high for more than one cycle");

endmodule

// Engine side with its own command channel
bind dma_copy_engine dma_top_chk chk_engine (
    .core_clk  (core_clk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .rsp_valid (rsp_valid),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .done      (done)
);

// Host channel of the fabric without a command path
bind bus_fabric dma_top_chk chk_host (
    .core_clk  (core_clk),
    .rst_n     (rst_n),
    .req_valid (host_req_valid),
    .req_ready (host_req_ready),
    .rsp_valid (host_rsp_valid),
    .cmd_valid (1'b0),
    .cmd_ready (1'b0),
    .done      (1'b0)
);

//--- bench/dma_top_tb.sv
module dma_top_tb import dma_pkg::*; ();

    localparam int CLK_PERIOD = 4;
    localparam int RST_CYCLES = 3;
    localparam int SEED       = 32'h10b;

    // Cycle budget, per host access, per copied word and per command
    localparam int ACC_CYC  = 4;
    localparam int WORD_CYC = 6;
    localparam int CMD_CYC  = 4;
    localparam int T1_CYC   = 32 * ACC_CYC;
    localparam int T2_CYC   = 3 * ACC_CYC;
    localparam int T3_CYC   = 8 * WORD_CYC + CMD_CYC + 16 * ACC_CYC;
    localparam int T4_CYC   = WORD_CYC + CMD_CYC + 9 * ACC_CYC;
    localparam int T5_CYC   = CMD_CYC + 4 * ACC_CYC;
    localparam int T6_CYC   = 32 * WORD_CYC + CMD_CYC + 88 * ACC_CYC;
    localparam int MAX_CYC  = 10 * (RST_CYCLES + T1_CYC + T2_CYC + T3_CYC
                                    + T4_CYC + T5_CYC + T6_CYC);

    logic     core_clk = 1'b0;
    logic     rst_n;
    logic     host_req_valid;
    logic     host_req_ready;
    mem_req_t host_req;
    logic     host_rsp_valid;
    mem_rsp_t host_rsp;
    logic     cmd_valid;
    logic     cmd_ready;
    dma_cmd_t cmd;
    logic     done;
    logic     done_err;

    addr_t sram_base;
    int    sram_words;
    data_t shadow [int];
    int    cycle_cnt = 0;
    int    err_count = 0;
    int    check_count = 0;
    int    tests_run = 0;
    int    tests_failed = 0;

    dma_top dut (
        .core_clk       (core_clk),
        .rst_n          (rst_n),
        .host_req_valid (host_req_valid),
        .host_req_ready (host_req_ready),
        .host_req       (host_req),
        .host_rsp_valid (host_rsp_valid),
        .host_rsp       (host_rsp),
        .cmd_valid      (cmd_valid),
        .cmd_ready      (cmd_ready),
        .cmd            (cmd),
        .done           (done),
        .done_err       (done_err)
    );

    always #(CLK_PERIOD / 2) core_clk = !core_clk;

    always @(posedge core_clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > MAX_CYC) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYC);
            $display("Finished with errors");
            $finish;
        end
    end

    function automatic addr_t word_addr(input int idx);
        return sram_base + addr_t'(idx);
    endfunction

    task automatic check_data(input string name, input data_t got, input data_t exp);
        check_count++;
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_err(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_done(input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: done_err got %b expected %b", $time, got, exp);
            err_count++;
        end
    endtask

    task automatic bus_access(input logic wr, input addr_t addr, input data_t wdata,
                              output mem_rsp_t rsp);
        @(negedge core_clk);
        host_req_valid = 1'b1;
        host_req.write = wr;
        host_req.addr  = addr;
        host_req.data  = wdata;
        // Ready follows the valid just driven, so look mid-cycle
        #1;
        while (!host_req_ready) begin
            @(negedge core_clk);
            #1;
        end
        @(negedge core_clk);
        host_req_valid = 1'b0;
        while (!host_rsp_valid) begin
            @(negedge core_clk);
        end
        rsp = host_rsp;
    endtask

    task automatic host_write(input addr_t addr, input data_t wdata, output mem_rsp_t rsp);
        bus_access(1'b1, addr, wdata, rsp);
    endtask

    task automatic host_read(input addr_t addr, output mem_rsp_t rsp);
        bus_access(1'b0, addr, '0, rsp);
    endtask

    task automatic run_cmd(input addr_t src, input addr_t dst, input int len,
                           output logic err, output int lat);
        @(negedge core_clk);
        cmd_valid = 1'b1;
        cmd.src   = src;
        cmd.dst   = dst;
        cmd.len   = len_t'(len);
        #1;
        while (!cmd_ready) begin
            @(negedge core_clk);
            #1;
        end
        @(negedge core_clk);
        cmd_valid = 1'b0;
        lat = 1;
        while (!done) begin
            @(negedge core_clk);
            lat++;
        end
        err = done_err;
    endtask

    task automatic store_word(input int idx, input data_t wdata);
        mem_rsp_t rsp;
        host_write(word_addr(idx), wdata, rsp);
        check_err($sformatf("host_rsp.err write word %0d", idx), rsp.err, 1'b0);
        shadow[idx] = wdata;
    endtask

    task automatic verify_word(input int idx);
        mem_rsp_t rsp;
        host_read(word_addr(idx), rsp);
        check_err($sformatf("host_rsp.err read word %0d", idx), rsp.err, 1'b0);
        check_data($sformatf("host_rsp.data word %0d", idx), rsp.data, shadow[idx]);
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (err_count == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, err_count - errs_before);
        end
    endtask

    task automatic test_fill_readback();
        int errs;
        errs = err_count;
        for (int i = 0; i < 16; i++) store_word(i, data_t'($urandom()));
        for (int i = 0; i < 16; i++) verify_word(i);
        report_test("fill_readback", errs);
    endtask

    task automatic test_unmapped();
        int       errs;
        addr_t    bad;
        mem_rsp_t rsp;
        errs = err_count;
        // Low bits alias word 0, so a bad decode would corrupt it
        bad = sram_base + addr_t'(sram_words);
        host_read(bad, rsp);
        check_err("host_rsp.err read unmapped", rsp.err, 1'b1);
        check_data("host_rsp.data read unmapped", rsp.data, '0);
        host_write(bad, data_t'($urandom()), rsp);
        check_err("host_rsp.err write unmapped", rsp.err, 1'b1);
        verify_word(0);
        report_test("unmapped", errs);
    endtask

    task automatic test_copy();
        int   errs;
        int   lat;
        logic err;
        errs = err_count;
        run_cmd(word_addr(0), word_addr(64), 8, err, lat);
        check_done(err, 1'b0);
        for (int i = 0; i < 8; i++) shadow[64 + i] = shadow[i];
        for (int i = 0; i < 8; i++) begin
            verify_word(64 + i);
            verify_word(i);
        end
        report_test("copy", errs);
    endtask

    task automatic test_copy_unmapped();
        int       errs;
        int       lat;
        int       alias_idx;
        logic     err;
        addr_t    bad;
        mem_rsp_t rsp;
        errs = err_count;
        alias_idx = sram_words / 2;
        for (int i = 0; i < 4; i++) store_word(alias_idx + i, data_t'($urandom()));
        bad = sram_base + addr_t'(sram_words + alias_idx);
        run_cmd(word_addr(0), bad, 4, err, lat);
        check_done(err, 1'b1);
        for (int i = 0; i < 4; i++) verify_word(alias_idx + i);
        host_read(bad, rsp);
        check_err("host_rsp.err read copy destination", rsp.err, 1'b1);
        report_test("copy_unmapped", errs);
    endtask

    task automatic test_zero_len();
        int   errs;
        int   lat;
        logic err;
        errs = err_count;
        run_cmd(word_addr(0), word_addr(sram_words / 2), 0, err, lat);
        check_done(err, 1'b0);
        if (lat != 2) begin
            $display("Zero-length command gave done after %0d cycles instead of 2", lat);
            err_count++;
        end
        for (int i = 0; i < 4; i++) verify_word(sram_words / 2 + i);
        report_test("zero_len", errs);
    endtask

    task automatic test_contention();
        int   errs;
        int   lat;
        logic err;
        errs = err_count;
        for (int i = 0; i < 32; i++) store_word(96 + i, data_t'($urandom()));
        for (int i = 0; i < 8; i++) store_word(200 + i, data_t'($urandom()));
        // Host reads compete with the engine for the fabric
        fork
            run_cmd(word_addr(96), word_addr(160), 32, err, lat);
            for (int i = 0; i < 16; i++) verify_word(200 + i % 8);
        join
        check_done(err, 1'b0);
        for (int i = 0; i < 32; i++) shadow[160 + i] = shadow[96 + i];
        for (int i = 0; i < 32; i++) verify_word(160 + i);
        report_test("contention", errs);
    endtask

    initial begin
        rst_n          = 1'b0;
        host_req_valid = 1'b0;
        host_req       = '0;
        cmd_valid      = 1'b0;
        cmd            = '0;
        void'($urandom(SEED));
        sram_base  = dut.SRAM_BASE;
        sram_words = 1 << dut.SRAM_AW;
        repeat (RST_CYCLES) @(posedge core_clk);
        @(negedge core_clk);
        rst_n = 1'b1;

        test_fill_readback();
        test_unmapped();
        test_copy();
        test_copy_unmapped();
        test_zero_len();
        test_contention();

        $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, check_count, err_count);
        if (err_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- hdl/bus_fabric.sv
module bus_fabric import dma_pkg::*; #(
    parameter int    SRAM_AW   = 8,
    parameter addr_t SRAM_BASE = 32'h4000_0000
) (
    input  logic     core_clk,
    input  logic     rst_n,

    // Host requester
    input  logic     host_req_valid,
    output logic     host_req_ready,
    input  mem_req_t host_req,
    output logic     host_rsp_valid,
    output mem_rsp_t host_rsp,

    // DMA engine requester
    input  logic     dma_req_valid,
    output logic     dma_req_ready,
    input  mem_req_t dma_req,
    output logic     dma_rsp_valid,
    output mem_rsp_t dma_rsp,

    // Toward the SRAM
    output logic     mem_req_valid,
    input  logic     mem_req_ready,
    output mem_req_t mem_req,
    input  logic     mem_rsp_valid,
    input  mem_rsp_t mem_rsp
);

    logic     busy;
    logic     owner_dma;
    logic     prio_dma;
    logic     err_rsp_valid;

    logic     grant_host;
    logic     grant_dma;
    logic     sel_valid;
    logic     sel_ready;
    logic     sel_hit;
    logic     xfer;
    logic     rsp_any;
    mem_req_t sel_req;
    mem_rsp_t rsp_mux;

    // Round-robin grant, frozen while a transaction is in flight
    assign grant_dma  = !busy && dma_req_valid && (!host_req_valid || prio_dma);
    assign grant_host = !busy && host_req_valid && (!dma_req_valid || !prio_dma);

    assign sel_req   = grant_dma ? dma_req : host_req;
    assign sel_valid = grant_dma || grant_host;
    assign sel_hit   = sel_req.addr[ADDR_W-1:SRAM_AW] == SRAM_BASE[ADDR_W-1:SRAM_AW];

    // Unmapped requests are taken at once by the local error slot
    assign sel_ready = sel_hit ? mem_req_ready : 1'b1;
    assign xfer      = sel_valid && sel_ready;

    assign host_req_ready = grant_host && sel_ready;
    assign dma_req_ready  = grant_dma && sel_ready;

    assign mem_req_valid = sel_valid && sel_hit;

    always_comb begin
        mem_req                   = sel_req;
        mem_req.addr              = '0;
        mem_req.addr[SRAM_AW-1:0] = sel_req.addr[SRAM_AW-1:0];
    end

    always_ff @(posedge core_clk) begin
        if (!rst_n) begin
            busy          <= 1'b0;
            owner_dma     <= 1'b0;
            prio_dma      <= 1'b0;
            err_rsp_valid <= 1'b0;
        end else begin
            err_rsp_valid <= xfer && !sel_hit;
            if (xfer) begin
                busy      <= 1'b1;
                owner_dma <= grant_dma;
                prio_dma  <= !grant_dma;
            end else if (rsp_any) begin
                busy <= 1'b0;
            end
        end
    end

    // Response back to whoever owns the transaction
    assign rsp_any = mem_rsp_valid || err_rsp_valid;

    always_comb begin
        rsp_mux = mem_rsp;
        if (err_rsp_valid) begin
            rsp_mux.data = '0;
            rsp_mux.err  = 1'b1;
        end
    end

    assign host_rsp_valid = rsp_any && !owner_dma;
    assign dma_rsp_valid  = rsp_any && owner_dma;
    assign host_rsp       = rsp_mux;
    assign dma_rsp        = rsp_mux;

endmodule

//--- hdl/bus_sram.sv
module bus_sram import dma_pkg::*; #(
    parameter int SRAM_AW = 8
) (
    input  logic     core_clk,
    input  logic     rst_n,

    input  logic     req_valid,
    output logic     req_ready,
    input  mem_req_t req,
    output logic     rsp_valid,
    output mem_rsp_t rsp
);

    localparam int DEPTH = 1 << SRAM_AW;

    data_t mem [DEPTH];

    logic               xfer;
    logic [SRAM_AW-1:0] idx;

    // Single response slot
    assign req_ready = !rsp_valid;
    assign xfer      = req_valid && req_ready;
    assign idx       = req.addr[SRAM_AW-1:0];

    always_ff @(posedge core_clk) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= xfer;
        end
    end

    // Read returns the old word, even on a write
    always_ff @(posedge core_clk) begin
        if (xfer) begin
            rsp.data <= mem[idx];
            rsp.err  <= 1'b0;
            if (req.write) begin
                mem[idx] <= req.data;
            end
        end
    end

endmodule

//--- hdl/dma_copy_engine.sv
module dma_copy_engine import dma_pkg::*; (
    input  logic     core_clk,
    input  logic     rst_n,

    // Command channel
    input  logic     cmd_valid,
    output logic     cmd_ready,
    input  dma_cmd_t cmd,

    // Bus requester port
    output logic     req_valid,
    input  logic     req_ready,
    output mem_req_t req,
    input  logic     rsp_valid,
    input  mem_rsp_t rsp,

    // Completion
    output logic     done,
    output logic     done_err
);

    engine_state_t state;

    addr_t src_addr;
    addr_t dst_addr;
    len_t  words_left;
    data_t word_buf;
    logic  err_seen;

    logic cmd_xfer;
    logic req_xfer;

    assign cmd_ready = (state == st_idle);
    assign cmd_xfer  = cmd_valid && cmd_ready;
    assign req_xfer  = req_valid && req_ready;

    // Bus request follows the state directly
    always_comb begin
        req_valid = 1'b0;
        req.write = 1'b0;
        req.addr  = src_addr;
        req.data  = '0;
        case (state)
            st_read: begin
                req_valid = 1'b1;
            end
            st_write: begin
                req_valid = 1'b1;
                req.write = 1'b1;
                req.addr  = dst_addr;
                req.data  = word_buf;
            end
            default: begin
                req_valid = 1'b0;
            end
        endcase
    end

    // Control FSM
    always_ff @(posedge core_clk) begin
        if (!rst_n) begin
            state    <= st_idle;
            err_seen <= 1'b0;
            done     <= 1'b0;
            done_err <= 1'b0;
        end else begin
            done     <= 1'b0;
            done_err <= 1'b0;
            case (state)
                st_idle: begin
                    if (cmd_xfer) begin
                        err_seen <= 1'b0;
                        // Nothing to move, report right away
                        if (cmd.len == '0) begin
                            state <= st_finish;
                        end else begin
                            state <= st_read;
                        end
                    end
                end
                st_read: begin
                    if (req_xfer) begin
                        state <= st_read_wait;
                    end
                end
                st_read_wait: begin
                    if (rsp_valid) begin
                        if (rsp.err) begin
                            err_seen <= 1'b1;
                            state    <= st_finish;
                        end else begin
                            state <= st_write;
                        end
                    end
                end
                st_write: begin
                    if (req_xfer) begin
                        state <= st_write_wait;
                    end
                end
                st_write_wait: begin
                    if (rsp_valid) begin
                        if (rsp.err) begin
                            err_seen <= 1'b1;
                            state    <= st_finish;
                        end else if (words_left == len_t'(1)) begin
                            state <= st_finish;
                        end else begin
                            state <= st_read;
                        end
                    end
                end
                st_finish: begin
                    done     <= 1'b1;
                    done_err <= err_seen;
                    state    <= st_idle;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // Address walk, word count and data buffer
    always_ff @(posedge core_clk) begin
        if (cmd_xfer) begin
            src_addr   <= cmd.src;
            dst_addr   <= cmd.dst;
            words_left <= cmd.len;
        end else if (state == st_write_wait && rsp_valid && !rsp.err) begin
            src_addr   <= src_addr + addr_t'(1);
            dst_addr   <= dst_addr + addr_t'(1);
            words_left <= words_left - len_t'(1);
        end
        if (state == st_read_wait && rsp_valid) begin
            word_buf <= rsp.data;
        end
    end

endmodule

//--- hdl/dma_pkg.sv
package dma_pkg;

    // Bus and command field widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int LEN_W  = 16;

    // Word address, no byte offset bits
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [LEN_W-1:0]  len_t;

    // One bus request
    typedef struct packed {
        logic  write;
        addr_t addr;
        data_t data;
    } mem_req_t;

    // One bus response
    typedef struct packed {
        data_t data;
        logic  err;
    } mem_rsp_t;

    // Copy command from the host
    typedef struct packed {
        addr_t src;
        addr_t dst;
        len_t  len;
    } dma_cmd_t;

    typedef enum logic [2:0] {
        st_idle,
        st_read,
        st_read_wait,
        st_write,
        st_write_wait,
        st_finish
    } engine_state_t;

endpackage

//--- hdl/dma_top.sv
module dma_top import dma_pkg::*; #(
    parameter int    SRAM_AW   = 8,
    parameter addr_t SRAM_BASE = 32'h4000_0000
) (
    input  logic     core_clk,
    input  logic     rst_n,

    // Host bus port
    input  logic     host_req_valid,
    output logic     host_req_ready,
    input  mem_req_t host_req,
    output logic     host_rsp_valid,
    output mem_rsp_t host_rsp,

    // Copy command and completion
    input  logic     cmd_valid,
    output logic     cmd_ready,
    input  dma_cmd_t cmd,
    output logic     done,
    output logic     done_err
);

    logic     dma_req_valid;
    logic     dma_req_ready;
    mem_req_t dma_req;
    logic     dma_rsp_valid;
    mem_rsp_t dma_rsp;

    logic     mem_req_valid;
    logic     mem_req_ready;
    mem_req_t mem_req;
    logic     mem_rsp_valid;
    mem_rsp_t mem_rsp;

    dma_copy_engine i_engine (
        .core_clk  (core_clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd       (cmd),
        .req_valid (dma_req_valid),
        .req_ready (dma_req_ready),
        .req       (dma_req),
        .rsp_valid (dma_rsp_valid),
        .rsp       (dma_rsp),
        .done      (done),
        .done_err  (done_err)
    );

    bus_fabric #(
        .SRAM_AW   (SRAM_AW),
        .SRAM_BASE (SRAM_BASE)
    ) i_fabric (
        .core_clk       (core_clk),
        .rst_n          (rst_n),
        .host_req_valid (host_req_valid),
        .host_req_ready (host_req_ready),
        .host_req       (host_req),
        .host_rsp_valid (host_rsp_valid),
        .host_rsp       (host_rsp),
        .dma_req_valid  (dma_req_valid),
        .dma_req_ready  (dma_req_ready),
        .dma_req        (dma_req),
        .dma_rsp_valid  (dma_rsp_valid),
        .dma_rsp        (dma_rsp),
        .mem_req_valid  (mem_req_valid),
        .mem_req_ready  (mem_req_ready),
        .mem_req        (mem_req),
        .mem_rsp_valid  (mem_rsp_valid),
        .mem_rsp        (mem_rsp)
    );

    // On-chip SRAM behind the fabric
    bus_sram #(
        .SRAM_AW (SRAM_AW)
    ) i_sram (
        .core_clk  (core_clk),
        .rst_n     (rst_n),
        .req_valid (mem_req_valid),
        .req_ready (mem_req_ready),
        .req       (mem_req),
        .rsp_valid (mem_rsp_valid),
        .rsp       (mem_rsp)
    );

endmodule

//--- run.sh
#!/bin/sh
# Build and run the DMA testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "Cannot enter the project root"
    exit 1
fi

LOG=sim.log

verilator --binary --timing --assert -f sources.f --top-module dma_top_tb -o dma_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/dma_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Finished with errors" "$LOG"; then
    exit 1
fi
exit 0

//--- sources.f
hdl/dma_pkg.sv
hdl/dma_copy_engine.sv
hdl/bus_fabric.sv
hdl/bus_sram.sv
hdl/dma_top.sv
bench/dma_top_chk.sv
bench/dma_top_tb.sv
